// ==== lcd_bus_pkg.sv ====
package lcd_bus_pkg;

  ////////////////////////////////////////////////////////////////////
  // 4-bit LCD bus transfer types
  ////////////////////////////////////////////////////////////////////

  typedef logic [3:0] nibble_t;  // d7..d4 on the pins

  typedef struct packed {
    logic    rs;                   // 1 = data register
    logic    rw;                   // 1 = read, never strobed
    nibble_t data;
  } lcd_word_t;

  typedef struct packed {
    logic      e;                  // enable strobe
    lcd_word_t word;
  } lcd_pins_t;

  typedef logic [7:0] char_t;

  localparam char_t CHAR_SPACE = 8'h20;

  ////////////////////////////////////////////////////////////////////
  // command words, high nibble first
  ////////////////////////////////////////////////////////////////////

  localparam lcd_word_t FN_SET_W   = '{rs: 1'b0, rw: 1'b0, data: 4'h2};  // 4-bit mode
  localparam lcd_word_t DISP_ON_HI = '{rs: 1'b0, rw: 1'b0, data: 4'h0};
  localparam lcd_word_t DISP_ON_LO = '{rs: 1'b0, rw: 1'b0, data: 4'hC};  // display on, no cursor
  localparam lcd_word_t CLEAR_HI   = '{rs: 1'b0, rw: 1'b0, data: 4'h0};
  localparam lcd_word_t CLEAR_LO   = '{rs: 1'b0, rw: 1'b0, data: 4'h1};
  localparam lcd_word_t ENTRY_HI   = '{rs: 1'b0, rw: 1'b0, data: 4'h0};
  localparam lcd_word_t ENTRY_LO   = '{rs: 1'b0, rw: 1'b0, data: 4'h6};  // increment, no shift
  localparam lcd_word_t LINE2_HI   = '{rs: 1'b0, rw: 1'b0, data: 4'hC};  // ddram address 40h
  localparam lcd_word_t LINE2_LO   = '{rs: 1'b0, rw: 1'b0, data: 4'h0};

  // parked word between transfers
  localparam lcd_word_t IDLE_W     = '{rs: 1'b0, rw: 1'b1, data: 4'h0};

endpackage

// ==== lock_screen_pkg.sv ====
package lock_screen_pkg;
  import lcd_bus_pkg::*;

  typedef enum logic [3:0] {
    INITIAL    = 4'd0,
    SET_PASS   = 4'd1,
    ENTER_PASS = 4'd2,
    CHECK_PASS = 4'd3,
    FAIL       = 4'd4,
    FREEZE     = 4'd5,
    SUCCESS    = 4'd6,
    OPEN_DOOR  = 4'd7,
    LOCK_DOOR  = 4'd8
  } lock_state_t;

  localparam int CODE_LEN  = 4;
  localparam int LINE1_LEN = 16;
  localparam int LINE2_LEN = 6;

  typedef struct packed {
    lock_state_t                state;
    char_t [CODE_LEN-1:0]       code;    // code[0] shown first
    char_t                      trials;
  } screen_ctx_t;

  ////////////////////////////////////////////////////////////////////
  // step numbering of the bus sequence
  ////////////////////////////////////////////////////////////////////

  typedef logic [5:0] step_t;
  typedef logic [1:0] phase_t;

  localparam int    FRAME_STEPS       = 50;
  localparam step_t STEP_POWERUP_LAST = 6'd4;
  localparam step_t STEP_FRAME_FIRST  = STEP_POWERUP_LAST + 6'd1;
  localparam step_t STEP_FRAME_LAST   = step_t'(STEP_FRAME_FIRST + FRAME_STEPS - 1);

  // first-line text, leftmost character in the top byte
  typedef logic [8*LINE1_LEN-1:0] line1_t;

  localparam line1_t TXT_INITIAL = "INITIAL         ";
  localparam line1_t TXT_SET     = "SET PASS        ";
  localparam line1_t TXT_ENTER   = "NHAP MAT KHAU   ";
  localparam line1_t TXT_CHECK   = "CHECK PASS      ";
  localparam line1_t TXT_FAIL    = "SAI MAT KHAU    ";
  localparam line1_t TXT_FREEZE  = "FREEZE          ";
  localparam line1_t TXT_SUCCESS = "DUNG MAT KHAU   ";
  localparam line1_t TXT_OPEN    = "CUA MO          ";
  localparam line1_t TXT_LOCK    = "CUA DONG        ";
  localparam line1_t TXT_BLANK   = {LINE1_LEN{CHAR_SPACE}};

  function automatic char_t line1_char(lock_state_t st, logic [3:0] pos);
    line1_t txt;
    case (st)
      INITIAL:    txt = TXT_INITIAL;
      SET_PASS:   txt = TXT_SET;
      ENTER_PASS: txt = TXT_ENTER;
      CHECK_PASS: txt = TXT_CHECK;
      FAIL:       txt = TXT_FAIL;
      FREEZE:     txt = TXT_FREEZE;
      SUCCESS:    txt = TXT_SUCCESS;
      OPEN_DOOR:  txt = TXT_OPEN;
      LOCK_DOOR:  txt = TXT_LOCK;
      default:    txt = TXT_BLANK;  // undefined states
    endcase
    return txt[8*(LINE1_LEN-1-int'(pos)) +: 8];
  endfunction

endpackage

// ==== lcd_step_timer.sv ====
module lcd_step_timer
  import lock_screen_pkg::*;
#(
  parameter int STEP_SHIFT = 17
) (
  input  logic   clk,
  input  logic   i_rst_n,
  output step_t  o_step,
  output phase_t o_phase,
  output logic   o_frame_start
);

  localparam int SUB_W = STEP_SHIFT + 2;  // phase bits on top

  logic [SUB_W-1:0] sub_cnt;
  step_t            step_q;
  logic             frame_start_q;
  logic             step_end;

  assign step_end = &sub_cnt;  // last clock of phase 3

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      sub_cnt       <= '0;
      step_q        <= '0;
      frame_start_q <= 1'b0;
    end else begin
      sub_cnt       <= sub_cnt + 1'b1;
      // next step is the frame start, from power-up or from wrap
      frame_start_q <= step_end &&
                       (step_q == STEP_POWERUP_LAST || step_q == STEP_FRAME_LAST);
      if (step_end) begin
        if (step_q == STEP_FRAME_LAST)
          step_q <= STEP_FRAME_FIRST;  // power-up steps never recur
        else
          step_q <= step_q + 1'b1;
      end
    end
  end

  assign o_step        = step_q;
  assign o_phase       = sub_cnt[SUB_W-1 -: 2];
  assign o_frame_start = frame_start_q;

endmodule

// ==== screen_snapshot.sv ====
module screen_snapshot
  import lcd_bus_pkg::*;
  import lock_screen_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_frame_start,
  input  screen_ctx_t i_ctx,
  output screen_ctx_t o_ctx
);

  localparam screen_ctx_t CTX_RESET = '{
    state:  INITIAL,
    code:   {CODE_LEN{CHAR_SPACE}},
    trials: CHAR_SPACE
  };

  screen_ctx_t ctx_q;

  // one capture per frame keeps state and characters consistent
  always_ff @(posedge clk) begin
    if (!i_rst_n)
      ctx_q <= CTX_RESET;
    else if (i_frame_start)
      ctx_q <= i_ctx;
  end

  assign o_ctx = ctx_q;

endmodule

// ==== lcd_word_sequencer.sv ====
module lcd_word_sequencer
  import lcd_bus_pkg::*;
  import lock_screen_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  input  step_t       i_step,
  input  screen_ctx_t i_ctx,
  output lcd_word_t   o_word
);

  //////////////////////////////////////////////////////////////////////
  // frame layout, derived from the frame start
  //////////////////////////////////////////////////////////////////////

  localparam step_t STEP_CLEAR     = STEP_FRAME_FIRST;
  localparam step_t STEP_ENTRY     = STEP_CLEAR + 6'd2;
  localparam step_t STEP_LINE1     = STEP_ENTRY + 6'd2;
  localparam step_t STEP_LINE2_CMD = step_t'(STEP_LINE1 + 2*LINE1_LEN);
  localparam step_t STEP_LINE2     = STEP_LINE2_CMD + 6'd2;

  function automatic lcd_word_t char_word(char_t c, logic lo);
    lcd_word_t w;
    w.rs   = 1'b1;
    w.rw   = 1'b0;
    w.data = lo ? c[3:0] : c[7:4];  // high nibble goes first
    return w;
  endfunction

  step_t     l1_off;
  step_t     l2_off;
  char_t     l1_chr;
  char_t     l2_chr;
  lcd_word_t word_d;
  lcd_word_t word_q;

  //////////////////////////////////////////////////////////////////////
  // character selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    l1_off = i_step - STEP_LINE1;
    l2_off = i_step - STEP_LINE2;
    l1_chr = line1_char(i_ctx.state, l1_off[4:1]);

    l2_chr = CHAR_SPACE;
    case (i_ctx.state)
      SET_PASS, ENTER_PASS: begin
        if (l2_off[3:1] < CODE_LEN)
          l2_chr = i_ctx.code[l2_off[2:1]];  // entered code
      end
      FAIL: begin
        if (l2_off[3:1] == 3'd0)
          l2_chr = i_ctx.trials;
      end
      default: l2_chr = CHAR_SPACE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // step to word
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (i_step)
      6'd0, 6'd1:         word_d = FN_SET_W;
      6'd2:               word_d = DISP_ON_LO;  // low half of function set, same code
      6'd3:               word_d = DISP_ON_HI;
      6'd4:               word_d = DISP_ON_LO;
      STEP_CLEAR:         word_d = CLEAR_HI;
      STEP_CLEAR + 6'd1:  word_d = CLEAR_LO;
      STEP_ENTRY:         word_d = ENTRY_HI;
      STEP_ENTRY + 6'd1:  word_d = ENTRY_LO;
      STEP_LINE2_CMD:     word_d = LINE2_HI;
      STEP_LINE2_CMD + 6'd1: word_d = LINE2_LO;
      default: begin
        if (i_step >= STEP_LINE1 && i_step < STEP_LINE2_CMD)
          word_d = char_word(l1_chr, l1_off[0]);
        else if (i_step >= STEP_LINE2 && i_step <= STEP_FRAME_LAST)
          word_d = char_word(l2_chr, l2_off[0]);
        else
          word_d = IDLE_W;  // unreachable steps
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n)
      word_q <= IDLE_W;
    else
      word_q <= word_d;
  end

  assign o_word = word_q;

endmodule

// ==== lcd_bus_driver.sv ====
module lcd_bus_driver
  import lcd_bus_pkg::*;
  import lock_screen_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  phase_t    i_phase,
  input  lcd_word_t i_word,
  output lcd_pins_t o_lcd
);

  logic      stb_q;  // one stage, matches the word register
  lcd_pins_t pins_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      stb_q  <= 1'b0;
      pins_q <= '{e: 1'b0, word: IDLE_W};
    end else begin
      stb_q  <= ^i_phase;  // high in phases 1 and 2
      pins_q <= '{e: stb_q, word: i_word};
    end
  end

  assign o_lcd = pins_q;

endmodule

// ==== lcd_status_display.sv ====
module lcd_status_display
  import lcd_bus_pkg::*;
  import lock_screen_pkg::*;
#(
  parameter int STEP_SHIFT = 17  // 2^STEP_SHIFT clocks per phase
) (
  input  logic        clk,
  input  logic        i_rst_n,
  input  screen_ctx_t i_ctx,
  output lcd_pins_t   o_lcd
);

  step_t       step;
  phase_t      phase;
  logic        frame_start;
  screen_ctx_t snap_ctx;
  lcd_word_t   word;

  lcd_step_timer #(
    .STEP_SHIFT (STEP_SHIFT)
  ) u_timer (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .o_step        (step),
    .o_phase       (phase),
    .o_frame_start (frame_start)
  );

  screen_snapshot u_snapshot (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_frame_start (frame_start),
    .i_ctx         (i_ctx),
    .o_ctx         (snap_ctx)
  );

  lcd_word_sequencer u_sequencer (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_step  (step),
    .i_ctx   (snap_ctx),
    .o_word  (word)
  );

  lcd_bus_driver u_driver (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_phase (phase),
    .i_word  (word),
    .o_lcd   (o_lcd)
  );

endmodule

// ==== lcd_status_display_asserts.sv ====
module lcd_status_display_asserts
  import lcd_bus_pkg::*;
(
  input logic      clk,
  input logic      i_rst_n,
  input lcd_pins_t i_lcd
);
  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////////////////////////
  // LCD pin rules
  //////////////////////////////////////////////////////////////////////

  // strobe parked low one clock into reset
  a_e_low_in_reset: assert property (@(posedge clk) !i_rst_n |=> !i_lcd.e)
    else $error("LCD enable high during reset");

  // data and rs settle a full phase before e
  a_word_stable: assert property (
    @(posedge clk) disable iff (!i_rst_n) i_lcd.e |-> $stable(i_lcd.word)
  ) else $error("LCD word changed while enable high");

  // bus is write-only
  a_write_only: assert property (
    @(posedge clk) disable iff (!i_rst_n) i_lcd.e |-> !i_lcd.word.rw
  ) else $error("LCD rw high while enable high");

endmodule

// ==== tb_lcd_status_display.sv ====
module tb_lcd_status_display
  import lcd_bus_pkg::*;
  import lock_screen_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED        = 70206;
  localparam int CLK_NS      = 100;
  localparam int STEP_CLKS   = 16;  // four phases of 4 clocks with STEP_SHIFT 2
  localparam int N_TESTS     = 5;
  localparam int FRAME_LEN   = 50;  // steps per frame
  // 3 frames per test plus power-up plus reset and margin
  localparam int WATCHDOG_NS = ((N_TESTS * 3 * FRAME_LEN + 5) * STEP_CLKS + 16 + 64) * CLK_NS;

  logic        clk = 1'b0;
  logic        rst_n;
  screen_ctx_t ctx;
  screen_ctx_t init_ctx;
  lcd_pins_t   lcd;

  lcd_status_display #(.STEP_SHIFT(2)) dut (.clk(clk), .i_rst_n(rst_n), .i_ctx(ctx), .o_lcd(lcd));

  bind lcd_status_display lcd_status_display_asserts u_asserts (
    .clk(clk), .i_rst_n(i_rst_n), .i_lcd(o_lcd)
  );

  always #(CLK_NS / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // expected values and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic lcd_word_t cmd_word(logic [3:0] d);
    lcd_word_t w;
    w.rs   = 1'b0;
    w.rw   = 1'b0;
    w.data = d;
    return w;
  endfunction

  function automatic char_t exp_line1_char(lock_state_t st, int pos);
    string s;
    case (st)
      INITIAL:    s = "INITIAL";
      SET_PASS:   s = "SET PASS";
      ENTER_PASS: s = "NHAP MAT KHAU";
      CHECK_PASS: s = "CHECK PASS";
      FAIL:       s = "SAI MAT KHAU";
      FREEZE:     s = "FREEZE";
      SUCCESS:    s = "DUNG MAT KHAU";
      OPEN_DOOR:  s = "CUA MO";
      LOCK_DOOR:  s = "CUA DONG";
      default:    s = "";
    endcase
    return (pos < s.len()) ? char_t'(s[pos]) : 8'h20;  // padded with spaces
  endfunction

  function automatic char_t exp_line2_char(screen_ctx_t c, int pos);
    char_t ch;
    ch = 8'h20;
    case (c.state)
      SET_PASS, ENTER_PASS: if (pos < CODE_LEN) ch = c.code[pos[1:0]];
      FAIL:                 if (pos == 0) ch = c.trials;
      default:              ch = 8'h20;
    endcase
    return ch;
  endfunction

  function automatic screen_ctx_t random_ctx(lock_state_t st);
    screen_ctx_t c;
    c.state = st;
    for (int i = 0; i < CODE_LEN; i++)
      c.code[i[1:0]] = char_t'($urandom_range(8'h7e, 8'h21));  // printable, no space
    c.trials = char_t'($urandom_range(8'h7e, 8'h21));
    return c;
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // word sampled on the falling clock once e has gone high
  task automatic capture_word(output lcd_word_t w);
    @(negedge clk);
    while (lcd.e !== 1'b0) @(negedge clk);
    while (lcd.e !== 1'b1) @(negedge clk);
    w = lcd.word;
  endtask

  task automatic apply_ctx(screen_ctx_t c);
    @(posedge clk);
    ctx <= c;
  endtask

  task automatic check_word(string name, lcd_word_t exp);
    lcd_word_t got;
    capture_word(got);
    if (got !== exp)
      fail_now($sformatf("Mismatch o_lcd.word (%s): expected %h, got %h", name, exp, got));
  endtask

  task automatic check_char(string name, char_t exp);
    lcd_word_t hi;
    lcd_word_t lo;
    char_t     got;
    capture_word(hi);
    capture_word(lo);
    if ({hi.rs, hi.rw, lo.rs, lo.rw} !== 4'b1010)
      fail_now($sformatf("Mismatch o_lcd.word rs/rw (%s): expected %h, got %h",
                         name, 4'b1010, {hi.rs, hi.rw, lo.rs, lo.rw}));
    got = {hi.data, lo.data};  // high nibble first
    if (got !== exp)
      fail_now($sformatf("Mismatch o_lcd.word.data (%s): expected %h, got %h",
                         name, exp, got));
  endtask

  task automatic check_cmd(string name, logic [3:0] hi, logic [3:0] lo);
    check_word({name, ".hi"}, cmd_word(hi));
    check_word({name, ".lo"}, cmd_word(lo));
  endtask

  task automatic check_line1(screen_ctx_t c, int first, int last);
    for (int i = first; i <= last; i++)
      check_char($sformatf("line1[%0d]", i), exp_line1_char(c.state, i));
  endtask

  task automatic check_line2(screen_ctx_t c);
    check_cmd("line2_addr", 4'hC, 4'h0);
    for (int i = 0; i < LINE2_LEN; i++)
      check_char($sformatf("line2[%0d]", i), exp_line2_char(c, i));
  endtask

  task automatic check_frame(screen_ctx_t c);
    check_cmd("clear", 4'h0, 4'h1);
    check_cmd("entry", 4'h0, 4'h6);
    check_line1(c, 0, 15);
    check_line2(c);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_power_up();
    check_word("powerup[0]", cmd_word(4'h2));
    check_word("powerup[1]", cmd_word(4'h2));
    check_word("powerup[2]", cmd_word(4'hC));
    check_word("powerup[3]", cmd_word(4'h0));
    check_word("powerup[4]", cmd_word(4'hC));
    check_frame(init_ctx);  // clear and entry follow directly
  endtask

  task automatic test_initial_frame();
    repeat (2) check_frame(init_ctx);
  endtask

  task automatic test_code_chars();
    screen_ctx_t c;
    c = random_ctx(ENTER_PASS);
    apply_ctx(c);
    check_frame(c);
    c = random_ctx(SET_PASS);
    apply_ctx(c);
    check_frame(c);
  endtask

  task automatic test_trials_and_blank();
    lock_state_t blank_states[5];
    screen_ctx_t c;
    blank_states = '{FREEZE, SUCCESS, OPEN_DOOR, LOCK_DOOR, CHECK_PASS};
    c = random_ctx(FAIL);
    apply_ctx(c);
    check_frame(c);
    foreach (blank_states[i]) begin
      c = random_ctx(blank_states[i]);  // code and trials must not show
      apply_ctx(c);
      check_frame(c);
    end
  endtask

  task automatic test_frame_snapshot();
    screen_ctx_t old_c;
    screen_ctx_t new_c;
    old_c = random_ctx(ENTER_PASS);
    new_c = random_ctx(SET_PASS);
    apply_ctx(old_c);
    check_cmd("clear", 4'h0, 4'h1);
    check_cmd("entry", 4'h0, 4'h6);
    check_line1(old_c, 0, 7);
    apply_ctx(new_c);  // mid line 1
    check_line1(old_c, 8, 15);
    check_line2(old_c);
    check_frame(new_c);
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_now($sformatf("timeout: tests did not finish within %0d ns", WATCHDOG_NS));
  end

  initial begin
    void'($urandom(SEED));
    init_ctx = random_ctx(INITIAL);
    rst_n    = 1'b0;
    ctx      = init_ctx;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_power_up();
    test_initial_frame();
    test_code_chars();
    test_trials_and_blank();
    test_frame_snapshot();
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== tb.f ====
lcd_bus_pkg.sv
lock_screen_pkg.sv
lcd_step_timer.sv
screen_snapshot.sv
lcd_word_sequencer.sv
lcd_bus_driver.sv
lcd_status_display.sv
lcd_status_display_asserts.sv
tb_lcd_status_display.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the LCD status display testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module tb_lcd_status_display \
  --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
